// File: proc_config.svh
/*
 * Processor configuration macros
 * Word width, register count, instruction field positions, reset PC
 */
`ifndef PROC_CONFIG_SVH
`define PROC_CONFIG_SVH

`define PROC_XLEN      16   // Data, address and instruction width
`define PROC_NREGS     16   // Architectural registers

// Instruction fields
`define PROC_OPC_MSB   15
`define PROC_OPC_LSB   12
`define PROC_RD_LSB    8    // Destination, also LW/SW data register
`define PROC_RS_LSB    4    // First source, LW/SW base
`define PROC_RT_LSB    0    // Second source, LW/SW offset

`define PROC_RESET_PC  0    // First fetch address
`define PROC_PC_STEP   2    // Byte addressed words

`endif

// File: proc_pkg.sv
/*
 * Processor package
 * Word and register index types, opcode and ALU enums, stage payloads
 */
`default_nettype none
`include "proc_config.svh"

package proc_pkg;

  typedef logic [`PROC_XLEN-1:0]          word_t;
  typedef logic [$clog2(`PROC_NREGS)-1:0] reg_idx_t;

  // Kept subset of the ISA, anything else runs as NOP
  typedef enum logic [3:0] {
    OP_ADD = 4'h0,
    OP_SUB = 4'h1,
    OP_XOR = 4'h2,
    OP_LW  = 4'h8,
    OP_SW  = 4'h9,
    OP_LLB = 4'hA,
    OP_LHB = 4'hB,
    OP_PCS = 4'hE,
    OP_HLT = 4'hF
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_XOR,
    ALU_LLB,     // Replace low byte of A
    ALU_LHB,     // Replace high byte of A
    ALU_PASS_B
  } alu_op_e;

  ////////////////////////////////////////////////////////////
  // Stage payloads
  ////////////////////////////////////////////////////////////
  typedef struct packed {
    word_t inst;
    word_t next_pc;
  } if_id_t;

  typedef struct packed {
    word_t    rs_val;
    word_t    rt_val;
    reg_idx_t rs;
    reg_idx_t rt;
    word_t    imm;
    alu_op_e  alu_op;
    logic     imm_sel;    // B operand from imm
    logic     mem_rd;
    logic     mem_wr;
    reg_idx_t rd;
    logic     reg_wr;
    logic     pcs;
    logic     hlt;
    word_t    next_pc;
  } id_ex_t;

  typedef struct packed {
    word_t    result;     // ALU result or data address
    word_t    store_data;
    logic     mem_rd;
    logic     mem_wr;
    reg_idx_t rd;
    logic     reg_wr;
    logic     pcs;
    logic     hlt;
    word_t    next_pc;
  } ex_mem_t;

  typedef struct packed {
    word_t    result;
    word_t    load_data;
    word_t    next_pc;
    reg_idx_t rd;
    logic     reg_wr;
    logic     mem_to_reg;
    logic     pcs;
    logic     hlt;
  } mem_wb_t;

endpackage

`default_nettype wire

// File: pipe_stage_reg.sv
/*
 * Generic pipeline register with advance, bubble and valid bit
 */
`default_nettype none
`timescale 1ns/1ns

module pipe_stage_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     arst_n,
  input  logic     advance,   // Whole pipe moves
  input  logic     bubble,    // Insert an empty slot instead of d
  input  payload_t d,
  input  logic     d_valid,
  output payload_t q,
  output logic     q_valid
);

  // Only the valid bit is control state
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      q_valid <= 1'b0;
    end else if (advance) begin
      q_valid <= d_valid & ~bubble;
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      q <= d;   // Payload is don't care when invalid
    end
  end

endmodule

`default_nettype wire

// File: fetch_unit.sv
/*
 * Fetch unit
 * PC register, one entry buffer for the fetched word, stop on HLT
 */
`default_nettype none
`timescale 1ns/1ns
`include "proc_config.svh"

module fetch_unit (
  input  logic            clk,
  input  logic            arst_n,
  input  logic            advance,
  input  logic            stall,       // Load-use hold
  input  logic            fetch_done,
  input  proc_pkg::word_t fetch_word,
  output logic            fetch_req,
  output proc_pkg::word_t pc,
  output proc_pkg::word_t fetch_addr,
  output proc_pkg::word_t inst,
  output logic            inst_valid
);
  import proc_pkg::*;

  logic  buf_valid;     // Buffer holds the word at pc
  word_t buf_word;
  logic  halt_fetched;  // HLT seen, no more fetches
  logic  consume;

  // Word leaves the buffer into IF/ID
  assign consume = advance & ~stall & buf_valid;

  assign fetch_req  = ~buf_valid & ~halt_fetched;
  assign fetch_addr = pc;
  assign inst       = buf_valid ? buf_word : '0;  // NOP once drained
  assign inst_valid = buf_valid;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc           <= word_t'(`PROC_RESET_PC);
      buf_valid    <= 1'b0;
      halt_fetched <= 1'b0;
    end else begin
      if (consume) begin
        pc        <= pc + word_t'(`PROC_PC_STEP);
        buf_valid <= 1'b0;
      end
      // Only reachable with an empty buffer
      if (fetch_done) begin
        buf_valid <= 1'b1;
        if (fetch_word[`PROC_OPC_MSB:`PROC_OPC_LSB] == OP_HLT) begin
          halt_fetched <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_done) begin
      buf_word <= fetch_word;
    end
  end

endmodule

`default_nettype wire

// File: mem_port_arbiter.sv
/*
 * Memory port arbiter
 * Shares one external port between data accesses and fetches
 * Tracks the single outstanding request and routes the answer
 */
`default_nettype none
`timescale 1ns/1ns

module mem_port_arbiter (
  input  logic            clk,
  input  logic            arst_n,
  // Memory stage request
  input  logic            data_req,
  input  logic            data_wr,
  input  proc_pkg::word_t data_addr,
  input  proc_pkg::word_t data_wdata,
  // Fetch request
  input  logic            fetch_req,
  input  proc_pkg::word_t fetch_addr,
  // External memory
  input  logic            mem_data_valid,
  input  proc_pkg::word_t mem_data_in,
  output logic            mem_en,        // One cycle strobe
  output logic            mem_wr,
  output proc_pkg::word_t mem_addr,
  output proc_pkg::word_t mem_data_out,
  // Completion back to requesters
  output logic            data_done,
  output logic            fetch_done,
  output proc_pkg::word_t rdata
);

  typedef enum logic {
    ST_IDLE,
    ST_BUSY
  } state_e;

  state_e state;
  logic   owner_data;   // Outstanding access belongs to the memory stage
  logic   issue;

  // Data wins when both are pending
  assign issue = (state == ST_IDLE) & (data_req | fetch_req);

  ////////////////////////////////////////////////////////////
  // Busy tracker and registered strobe
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state      <= ST_IDLE;
      owner_data <= 1'b0;
      mem_en     <= 1'b0;
      mem_wr     <= 1'b0;
    end else begin
      mem_en <= issue;                      // Falls again next cycle since busy
      mem_wr <= issue & data_req & data_wr;
      case (state)
        ST_IDLE: begin
          if (issue) begin
            state      <= ST_BUSY;
            owner_data <= data_req;
          end
        end
        ST_BUSY: begin
          if (mem_data_valid) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Address and write data launched with the strobe
  always_ff @(posedge clk) begin
    if (issue) begin
      mem_addr     <= data_req ? data_addr : fetch_addr;
      mem_data_out <= data_wdata;
    end
  end

  // Answer goes to whoever owns the access
  assign data_done  = (state == ST_BUSY) & mem_data_valid & owner_data;
  assign fetch_done = (state == ST_BUSY) & mem_data_valid & ~owner_data;
  assign rdata      = mem_data_in;

endmodule

`default_nettype wire

// File: decode_regfile.sv
/*
 * Decode stage
 * Instruction field split, control decode, 16 entry register file
 */
`default_nettype none
`timescale 1ns/1ns
`include "proc_config.svh"

module decode_regfile (
  input  logic               clk,
  input  logic               arst_n,
  input  proc_pkg::word_t    inst,
  input  logic               inst_valid,
  input  proc_pkg::word_t    next_pc,
  // Write-back port
  input  logic               wb_en,
  input  proc_pkg::reg_idx_t wb_rd,
  input  proc_pkg::word_t    wb_data,
  output proc_pkg::id_ex_t   id_out,
  output proc_pkg::reg_idx_t rs,     // Read indices, also to hazard check
  output proc_pkg::reg_idx_t rt
);
  import proc_pkg::*;

  localparam int IDX_W = $bits(reg_idx_t);

  word_t    regs [`PROC_NREGS];
  opcode_e  opc;
  reg_idx_t f_rd;
  reg_idx_t f_rs;
  reg_idx_t f_rt;
  word_t    off_x2;   // LW/SW offset in bytes
  word_t    imm8;     // LLB/LHB byte

  assign opc  = opcode_e'(inst[`PROC_OPC_MSB:`PROC_OPC_LSB]);
  assign f_rd = inst[`PROC_RD_LSB +: IDX_W];
  assign f_rs = inst[`PROC_RS_LSB +: IDX_W];
  assign f_rt = inst[`PROC_RT_LSB +: IDX_W];

  assign off_x2 = {{(`PROC_XLEN-IDX_W-1){f_rt[IDX_W-1]}}, f_rt, 1'b0};
  assign imm8   = word_t'(inst[7:0]);

  // Register read selection
  always_comb begin
    rs = f_rs;
    rt = f_rt;
    case (opc)
      OP_LLB, OP_LHB: rs = f_rd;   // Old value keeps its other byte
      OP_SW:          rt = f_rd;   // Store source
      default: ;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Control decode
  ////////////////////////////////////////////////////////////
  always_comb begin
    id_out         = '0;
    id_out.rs      = rs;
    id_out.rt      = rt;
    // Write-before-read bypass
    id_out.rs_val  = (wb_en && wb_rd == rs) ? wb_data : regs[rs];
    id_out.rt_val  = (wb_en && wb_rd == rt) ? wb_data : regs[rt];
    id_out.rd      = f_rd;
    id_out.next_pc = next_pc;
    id_out.alu_op  = ALU_ADD;
    if (inst_valid) begin
      case (opc)
        OP_ADD: begin
          id_out.alu_op = ALU_ADD;
          id_out.reg_wr = 1'b1;
        end
        OP_SUB: begin
          id_out.alu_op = ALU_SUB;
          id_out.reg_wr = 1'b1;
        end
        OP_XOR: begin
          id_out.alu_op = ALU_XOR;
          id_out.reg_wr = 1'b1;
        end
        OP_LLB, OP_LHB: begin
          id_out.alu_op  = (opc == OP_LLB) ? ALU_LLB : ALU_LHB;
          id_out.imm     = imm8;
          id_out.imm_sel = 1'b1;
          id_out.reg_wr  = 1'b1;
        end
        OP_LW, OP_SW: begin
          id_out.alu_op  = ALU_ADD;       // Base plus offset
          id_out.imm     = off_x2;
          id_out.imm_sel = 1'b1;
          id_out.mem_rd  = (opc == OP_LW);
          id_out.mem_wr  = (opc == OP_SW);
          id_out.reg_wr  = (opc == OP_LW);
        end
        OP_PCS: begin
          id_out.alu_op  = ALU_PASS_B;    // Return address through the ALU for forwarding
          id_out.imm     = next_pc;
          id_out.imm_sel = 1'b1;
          id_out.reg_wr  = 1'b1;
          id_out.pcs     = 1'b1;
        end
        OP_HLT:  id_out.hlt = 1'b1;
        default: ;                        // Unknown opcode, NOP
      endcase
    end
  end

  // Register file
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `PROC_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_en) begin
      regs[wb_rd] <= wb_data;
    end
  end

endmodule

`default_nettype wire

// File: execute_fwd.sv
/*
 * Execute stage
 * Operand forwarding, ALU, load/store address and store data
 */
`default_nettype none
`timescale 1ns/1ns
`include "proc_config.svh"

module execute_fwd (
  input  proc_pkg::id_ex_t   id_ex,
  // Forward sources, enables already include valid
  input  logic               ex_mem_fwd_en,
  input  proc_pkg::reg_idx_t ex_mem_rd,
  input  proc_pkg::word_t    ex_mem_val,
  input  logic               mem_wb_fwd_en,
  input  proc_pkg::reg_idx_t mem_wb_rd,
  input  proc_pkg::word_t    wb_val,
  output proc_pkg::ex_mem_t  ex_out
);
  import proc_pkg::*;

  word_t op_a;
  word_t op_b_reg;    // Forwarded rt, also store data
  word_t op_b;
  word_t result;

  // Youngest producer wins
  function automatic word_t fwd(reg_idx_t idx, word_t reg_val);
    if (ex_mem_fwd_en && ex_mem_rd == idx) begin
      return ex_mem_val;
    end
    if (mem_wb_fwd_en && mem_wb_rd == idx) begin
      return wb_val;
    end
    return reg_val;
  endfunction

  always_comb begin
    op_a     = fwd(id_ex.rs, id_ex.rs_val);
    op_b_reg = fwd(id_ex.rt, id_ex.rt_val);
    op_b     = id_ex.imm_sel ? id_ex.imm : op_b_reg;
    case (id_ex.alu_op)
      ALU_ADD: result = op_a + op_b;    // Wraps at 16 bits
      ALU_SUB: result = op_a - op_b;
      ALU_XOR: result = op_a ^ op_b;
      ALU_LLB: result = {op_a[`PROC_XLEN-1:8], op_b[7:0]};
      ALU_LHB: result = {op_b[7:0], op_a[7:0]};
      default: result = op_b;           // PASS_B
    endcase
  end

  assign ex_out.result     = result;
  assign ex_out.store_data = op_b_reg;
  assign ex_out.mem_rd     = id_ex.mem_rd;
  assign ex_out.mem_wr     = id_ex.mem_wr;
  assign ex_out.rd         = id_ex.rd;
  assign ex_out.reg_wr     = id_ex.reg_wr;
  assign ex_out.pcs        = id_ex.pcs;
  assign ex_out.hlt        = id_ex.hlt;
  assign ex_out.next_pc    = id_ex.next_pc;

endmodule

`default_nettype wire

// File: hazard_unit.sv
/*
 * Hazard unit
 * Global advance, load-use stall and ID/EX bubble
 */
`default_nettype none
`timescale 1ns/1ns

module hazard_unit (
  input  logic               ex_is_load,          // Valid LW in ID/EX
  input  proc_pkg::reg_idx_t ex_rd,
  input  proc_pkg::reg_idx_t id_rs,
  input  proc_pkg::reg_idx_t id_rt,
  input  logic               mem_access_pending,  // Unfinished LW/SW in MEM
  input  logic               data_done,
  input  logic               inst_valid,          // Fetch buffer full
  input  logic               halt_fetched,
  output logic               advance,
  output logic               stall,
  output logic               id_ex_bubble
);

  logic mem_ready;
  logic fetch_ready;
  logic load_use;

  assign mem_ready   = ~mem_access_pending | data_done;
  assign fetch_ready = inst_valid | halt_fetched;   // NOPs follow HLT
  assign advance     = mem_ready & fetch_ready;

  // Loaded value not yet available to the next instruction
  assign load_use = ex_is_load & ((ex_rd == id_rs) | (ex_rd == id_rt));

  assign stall        = load_use;             // Holds PC and IF/ID
  assign id_ex_bubble = advance & load_use;

endmodule

`default_nettype wire

// File: proc_core.sv
/*
 * Processor core top level
 * Five stage pipeline, shared memory port, write-back select
 */
`default_nettype none
`timescale 1ns/1ns
`include "proc_config.svh"

module proc_core (
  input  logic            clk,
  input  logic            arst_n,
  input  logic            mem_data_valid,
  input  proc_pkg::word_t mem_data_in,
  output logic            mem_en,
  output logic            mem_wr,
  output proc_pkg::word_t mem_addr,
  output proc_pkg::word_t mem_data_out,
  output logic            hlt,
  output proc_pkg::word_t pc
);
  import proc_pkg::*;

  logic     fetch_req, fetch_done, inst_valid, halt_fetched;
  word_t    fetch_addr, fetch_inst, rdata, load_q;
  logic     data_req, data_done, data_served;
  logic     advance, stall, id_ex_bubble;
  reg_idx_t id_rs, id_rt;
  if_id_t   if_id_d, if_id_q;
  id_ex_t   id_ex_d, id_ex_q;
  ex_mem_t  ex_mem_d, ex_mem_q;
  mem_wb_t  mem_wb_d, mem_wb_q;
  logic     if_id_valid, id_ex_valid, ex_mem_valid, mem_wb_valid;
  logic     wb_en;
  word_t    wb_val;

  ////////////////////////////////////////////////////////////
  // Fetch and memory port
  ////////////////////////////////////////////////////////////
  fetch_unit u_fetch (
    .clk, .arst_n, .advance, .stall, .fetch_done,
    .fetch_word (rdata),
    .fetch_req, .pc, .fetch_addr,
    .inst       (fetch_inst),
    .inst_valid
  );

  // Empty buffer with no request means HLT was fetched
  assign halt_fetched = ~inst_valid & ~fetch_req;

  mem_port_arbiter u_arb (
    .clk, .arst_n, .data_req,
    .data_wr    (ex_mem_q.mem_wr),
    .data_addr  (ex_mem_q.result),
    .data_wdata (ex_mem_q.store_data),
    .fetch_req, .fetch_addr, .mem_data_valid, .mem_data_in,
    .mem_en, .mem_wr, .mem_addr, .mem_data_out,
    .data_done, .fetch_done, .rdata
  );

  assign if_id_d.inst    = fetch_inst;
  assign if_id_d.next_pc = pc + word_t'(`PROC_PC_STEP);

  pipe_stage_reg #(.payload_t(if_id_t)) u_if_id (
    .clk, .arst_n,
    .advance (advance & ~stall), .bubble (1'b0),
    .d (if_id_d), .d_valid (inst_valid), .q (if_id_q), .q_valid (if_id_valid)
  );

  ////////////////////////////////////////////////////////////
  // Decode, hazards, execute
  ////////////////////////////////////////////////////////////
  decode_regfile u_decode (
    .clk, .arst_n,
    .inst (if_id_q.inst), .inst_valid (if_id_valid), .next_pc (if_id_q.next_pc),
    .wb_en, .wb_rd (mem_wb_q.rd), .wb_data (wb_val),
    .id_out (id_ex_d), .rs (id_rs), .rt (id_rt)
  );

  hazard_unit u_hazard (
    .ex_is_load (id_ex_valid & id_ex_q.mem_rd),
    .ex_rd      (id_ex_q.rd),
    .id_rs, .id_rt,
    .mem_access_pending (data_req),
    .data_done, .inst_valid, .halt_fetched,
    .advance, .stall, .id_ex_bubble
  );

  pipe_stage_reg #(.payload_t(id_ex_t)) u_id_ex (
    .clk, .arst_n, .advance, .bubble (id_ex_bubble),
    .d (id_ex_d), .d_valid (if_id_valid), .q (id_ex_q), .q_valid (id_ex_valid)
  );

  // Loads in EX/MEM have no value yet, the stall covers them
  execute_fwd u_execute (
    .id_ex         (id_ex_q),
    .ex_mem_fwd_en (ex_mem_valid & ex_mem_q.reg_wr & ~ex_mem_q.mem_rd),
    .ex_mem_rd     (ex_mem_q.rd),
    .ex_mem_val    (ex_mem_q.result),
    .mem_wb_fwd_en (wb_en),
    .mem_wb_rd     (mem_wb_q.rd),
    .wb_val,
    .ex_out        (ex_mem_d)
  );

  pipe_stage_reg #(.payload_t(ex_mem_t)) u_ex_mem (
    .clk, .arst_n, .advance, .bubble (1'b0),
    .d (ex_mem_d), .d_valid (id_ex_valid), .q (ex_mem_q), .q_valid (ex_mem_valid)
  );

  ////////////////////////////////////////////////////////////
  // Memory stage
  ////////////////////////////////////////////////////////////
  // Finished access stays masked until EX/MEM moves on
  assign data_req = ex_mem_valid & (ex_mem_q.mem_rd | ex_mem_q.mem_wr) & ~data_served;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      data_served <= 1'b0;
    end else if (advance) begin
      data_served <= 1'b0;
    end else if (data_done) begin
      data_served <= 1'b1;   // Waiting on fetch before moving
    end
  end

  always_ff @(posedge clk) begin
    if (data_done) begin
      load_q <= rdata;       // Load word held until advance
    end
  end

  assign mem_wb_d.result     = ex_mem_q.result;
  assign mem_wb_d.load_data  = data_done ? rdata : load_q;
  assign mem_wb_d.next_pc    = ex_mem_q.next_pc;
  assign mem_wb_d.rd         = ex_mem_q.rd;
  assign mem_wb_d.reg_wr     = ex_mem_q.reg_wr;
  assign mem_wb_d.mem_to_reg = ex_mem_q.mem_rd;
  assign mem_wb_d.pcs        = ex_mem_q.pcs;
  assign mem_wb_d.hlt        = ex_mem_q.hlt;

  // Freezes on HLT so hlt stays high
  pipe_stage_reg #(.payload_t(mem_wb_t)) u_mem_wb (
    .clk, .arst_n, .advance (advance & ~hlt), .bubble (1'b0),
    .d (mem_wb_d), .d_valid (ex_mem_valid), .q (mem_wb_q), .q_valid (mem_wb_valid)
  );

  // Write-back select
  assign wb_en  = mem_wb_valid & mem_wb_q.reg_wr;
  assign wb_val = mem_wb_q.mem_to_reg ? mem_wb_q.load_data :
                  mem_wb_q.pcs        ? mem_wb_q.next_pc   :
                                        mem_wb_q.result;
  assign hlt    = mem_wb_valid & mem_wb_q.hlt;

endmodule

`default_nettype wire

// File: proc_chk.sv
/*
 * Bound protocol checker for the processor core
 * Reset state, single strobe handshake, first fetch, halt behaviour
 */
`default_nettype none
`timescale 1ns/1ns

module proc_chk (
  input logic            clk,
  input logic            arst_n,
  input logic            mem_en,
  input logic            mem_wr,
  input proc_pkg::word_t mem_addr,
  input logic            mem_data_valid,
  input logic            hlt,
  input proc_pkg::word_t pc
);

  logic failed;       // Sticky, read by the testbench
  logic rst_q;        // Reset was low at the previous edge
  logic first_req;    // No request issued since reset
  logic outstanding;  // Request issued, answer not yet seen

  initial failed = 1'b0;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rst_q       <= 1'b1;
      first_req   <= 1'b1;
      outstanding <= 1'b0;
    end else begin
      rst_q <= 1'b0;
      if (mem_en) begin
        first_req   <= 1'b0;
        outstanding <= 1'b1;
      end else if (mem_data_valid) begin
        outstanding <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Reset and handshake
  ////////////////////////////////////////////////////////////
  a_reset_state: assert property (@(posedge clk)
    (!arst_n || rst_q) |-> (!mem_en && !mem_wr && !hlt && pc == '0))
    else begin
      failed <= 1'b1;
      $error("outputs not idle during or right after reset");
    end

  a_first_fetch: assert property (@(posedge clk) disable iff (!arst_n)
    (first_req && mem_en) |-> (!mem_wr && mem_addr == '0))
    else begin
      failed <= 1'b1;
      $error("ERROR mem_addr first request got %h exp 0000", mem_addr);
    end

  a_one_cycle: assert property (@(posedge clk) disable iff (!arst_n) mem_en |=> !mem_en)
    else begin
      failed <= 1'b1;
      $error("mem_en held high for two cycles");
    end

  // Only one access in flight
  a_no_overlap: assert property (@(posedge clk) disable iff (!arst_n) outstanding |-> !mem_en)
    else begin
      failed <= 1'b1;
      $error("new request issued before the previous answer");
    end

  ////////////////////////////////////////////////////////////
  // Halt
  ////////////////////////////////////////////////////////////
  a_hlt_sticky: assert property (@(posedge clk) disable iff (!arst_n) hlt |=> hlt)
    else begin
      failed <= 1'b1;
      $error("hlt dropped before reset");
    end

  a_hlt_quiet: assert property (@(posedge clk) disable iff (!arst_n) hlt |-> !mem_en)
    else begin
      failed <= 1'b1;
      $error("memory request issued after halt");
    end

  a_hlt_pc: assert property (@(posedge clk) disable iff (!arst_n) hlt |=> $stable(pc))
    else begin
      failed <= 1'b1;
      $error("ERROR pc moved to %h while halted", pc);
    end

endmodule

bind proc_core proc_chk u_chk (
  .clk            (clk),
  .arst_n         (arst_n),
  .mem_en         (mem_en),
  .mem_wr         (mem_wr),
  .mem_addr       (mem_addr),
  .mem_data_valid (mem_data_valid),
  .hlt            (hlt),
  .pc             (pc)
);

`default_nettype wire

// File: tb_proc.sv
/*
 * Testbench for the processor core
 * Clock, reset, random latency memory model, two programs
 * Sequential ISA model for expected stores, loads and halt PC
 */
`default_nettype none
`timescale 1ns/1ns

module tb_proc;
  import proc_pkg::*;

  localparam int    CLK_PERIOD    = 4;
  localparam int    RST_CYCLES    = 16;
  localparam int    N_PROGS       = 2;
  localparam int    MAX_INSTR     = 40;
  localparam int    CYC_PER_INSTR = 12;
  localparam int    MEM_WORDS     = 256;
  localparam int    SEED          = 66010;
  localparam word_t DATA_BASE     = 16'h0080;  // Reads at or above are data accesses

  logic  clk;
  logic  arst_n;
  logic  mem_data_valid;
  word_t mem_data_in;
  logic  mem_en;
  logic  mem_wr;
  logic  hlt;
  word_t mem_addr;
  word_t mem_data_out;
  word_t pc;

  word_t mem [MEM_WORDS];       // DUT side memory
  word_t ref_mem [MEM_WORDS];   // Model copy
  word_t ref_regs [16];
  word_t prog [$];
  word_t exp_st_addr [$];
  word_t exp_st_data [$];
  word_t exp_ld_addr [$];
  word_t exp_halt_pc;
  word_t fetch_pc;              // Next expected fetch address
  word_t rd_word;
  bit    busy;
  int    wait_cnt;
  int    st_idx;
  int    ld_idx;
  int    errors;
  int    tests_failed;
  logic  chk_fail;

  proc_core u_dut (
    .clk, .arst_n, .mem_data_valid, .mem_data_in,
    .mem_en, .mem_wr, .mem_addr, .mem_data_out, .hlt, .pc
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  ////////////////////////////////////////////////////////////
  // Assembler helpers and reference model
  ////////////////////////////////////////////////////////////
  function automatic word_t enc_r(opcode_e op, int rd, int rs, int rt);
    return {op, 4'(rd), 4'(rs), 4'(rt)};
  endfunction

  function automatic word_t enc_i(opcode_e op, int rd, int imm8);
    return {op, 4'(rd), 8'(imm8)};
  endfunction

  task automatic load_memory();
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = {8'(i), 8'(i) ^ 8'h5A};   // Fill follows the word address
    end
    for (int i = 0; i < prog.size(); i++) begin
      mem[i] = prog[i];
    end
    ref_mem = mem;
  endtask

  // Executes the program one instruction at a time
  task automatic run_model();
    word_t iw;
    word_t a;
    word_t b;
    word_t addr;
    int    off;
    int    pcw;
    bit    done;
    exp_st_addr.delete();
    exp_st_data.delete();
    exp_ld_addr.delete();
    for (int i = 0; i < 16; i++) begin
      ref_regs[i] = '0;
    end
    pcw  = 0;
    done = 1'b0;
    while (!done && pcw / 2 < prog.size()) begin
      iw   = prog[pcw / 2];
      a    = ref_regs[iw[7:4]];
      b    = ref_regs[iw[3:0]];
      off  = iw[3] ? int'(iw[3:0]) - 16 : int'(iw[3:0]);  // Signed word offset
      addr = a + word_t'(2 * off);
      case (opcode_e'(iw[15:12]))
        OP_ADD: ref_regs[iw[11:8]] = a + b;
        OP_SUB: ref_regs[iw[11:8]] = a - b;
        OP_XOR: ref_regs[iw[11:8]] = a ^ b;
        OP_LLB: ref_regs[iw[11:8]] = {ref_regs[iw[11:8]][15:8], iw[7:0]};
        OP_LHB: ref_regs[iw[11:8]] = {iw[7:0], ref_regs[iw[11:8]][7:0]};
        OP_LW: begin
          ref_regs[iw[11:8]] = ref_mem[addr[8:1]];
          exp_ld_addr.push_back(addr);
        end
        OP_SW: begin
          ref_mem[addr[8:1]] = ref_regs[iw[11:8]];
          exp_st_addr.push_back(addr);
          exp_st_data.push_back(ref_regs[iw[11:8]]);
        end
        OP_PCS: ref_regs[iw[11:8]] = word_t'(pcw + 2);
        OP_HLT: begin
          done        = 1'b1;
          exp_halt_pc = word_t'(pcw + 2);
        end
        default: ;   // NOP
      endcase
      pcw = pcw + 2;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Memory model
  ////////////////////////////////////////////////////////////
  task automatic check_access();
    word_t a;
    a = mem_addr;
    rd_word = mem[a[8:1]];
    if (mem_wr) begin
      mem[a[8:1]] = mem_data_out;
      assert (st_idx < exp_st_addr.size()) else begin
        $display("store to %h is not in the expected list", a);
        errors++;
      end
      if (st_idx < exp_st_addr.size()) begin
        assert (a == exp_st_addr[st_idx]) else begin
          $display("ERROR mem_addr got %h exp %h (store)", a, exp_st_addr[st_idx]);
          errors++;
        end
        assert (mem_data_out == exp_st_data[st_idx]) else begin
          $display("ERROR mem_data_out got %h exp %h", mem_data_out, exp_st_data[st_idx]);
          errors++;
        end
      end
      st_idx++;
    end else if (a >= DATA_BASE) begin
      assert (ld_idx < exp_ld_addr.size() && a == exp_ld_addr[ld_idx]) else begin
        $display("ERROR mem_addr got %h (load %0d not expected there)", a, ld_idx);
        errors++;
      end
      ld_idx++;
    end else begin
      assert (a == fetch_pc) else begin
        $display("ERROR mem_addr got %h exp %h (fetch)", a, fetch_pc);
        errors++;
      end
      fetch_pc = fetch_pc + 16'd2;
    end
  endtask

  // Looks at stable DUT outputs and drives the answer 1 ns after the edge
  always @(posedge clk) begin
    #1;
    mem_data_valid = 1'b0;
    if (!arst_n) begin
      busy = 1'b0;
    end else begin
      if (busy) begin
        wait_cnt--;
        if (wait_cnt == 0) begin
          mem_data_valid = 1'b1;
          mem_data_in    = rd_word;
          busy           = 1'b0;
        end
      end
      if (mem_en) begin
        busy     = 1'b1;
        wait_cnt = $urandom_range(4, 1);  // 1 to 4 cycles
        check_access();
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Programs
  ////////////////////////////////////////////////////////////
  // ALU ops, byte loads, forwarding chains, PCS
  task automatic build_prog_a();
    prog.delete();
    prog.push_back(enc_i(OP_LLB, 1, 8'h90));   // Base pointer
    prog.push_back(enc_i(OP_LLB, 2, 8'h34));
    prog.push_back(enc_i(OP_LHB, 2, 8'h12));   // Keeps the low byte just written
    prog.push_back(enc_i(OP_LLB, 3, 8'hFF));
    prog.push_back(enc_r(OP_ADD, 4, 2, 3));    // Both forwarding paths
    prog.push_back(enc_r(OP_SUB, 5, 3, 2));    // Wraps below zero
    prog.push_back(enc_r(OP_XOR, 6, 4, 5));
    prog.push_back(enc_r(OP_SW, 4, 1, 0));
    prog.push_back(enc_r(OP_SW, 5, 1, 1));
    prog.push_back(enc_r(OP_SW, 6, 1, 2));
    prog.push_back(enc_r(OP_PCS, 7, 0, 0));
    prog.push_back(enc_r(OP_ADD, 8, 7, 7));    // PCS result forwarded
    prog.push_back(enc_r(OP_SW, 7, 1, 3));
    prog.push_back(enc_r(OP_SW, 8, 1, 4));
    prog.push_back(enc_i(OP_LHB, 9, 8'hFF));
    prog.push_back(enc_r(OP_ADD, 9, 9, 2));    // Carry out dropped
    prog.push_back(enc_r(OP_SW, 9, 1, 15));    // Negative offset
    prog.push_back(enc_r(OP_XOR, 10, 9, 9));
    prog.push_back(enc_r(OP_SUB, 11, 10, 3));
    prog.push_back(enc_r(OP_SW, 11, 1, 5));
    prog.push_back(enc_r(OP_HLT, 0, 0, 0));
  endtask

  // Load-use chains and load to store data
  task automatic build_prog_b();
    prog.delete();
    prog.push_back(enc_i(OP_LLB, 1, 8'h90));
    prog.push_back(enc_r(OP_LW, 2, 1, 0));
    prog.push_back(enc_r(OP_ADD, 3, 2, 2));    // Load-use on rs
    prog.push_back(enc_r(OP_LW, 4, 1, 1));
    prog.push_back(enc_r(OP_SW, 4, 1, 4));     // Loaded word stored straight back
    prog.push_back(enc_r(OP_LW, 5, 1, 2));
    prog.push_back(enc_r(OP_SUB, 6, 1, 5));    // Load-use on rt
    prog.push_back(16'h4321);                  // Unknown opcode
    prog.push_back(enc_r(OP_SW, 3, 1, 5));
    prog.push_back(enc_r(OP_SW, 6, 1, 6));
    prog.push_back(enc_r(OP_LW, 7, 1, 4));     // Reads the earlier store
    prog.push_back(enc_r(OP_XOR, 8, 7, 3));
    prog.push_back(enc_r(OP_SW, 8, 1, 7));
    prog.push_back(enc_r(OP_HLT, 0, 0, 0));
  endtask

  task automatic run_program(string name);
    int   err0;
    logic chk0;
    bit   bad;
    err0 = errors;
    chk0 = u_dut.u_chk.failed;
    load_memory();
    run_model();
    st_idx   = 0;
    ld_idx   = 0;
    fetch_pc = '0;
    @(posedge clk);
    #1 arst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    #1 arst_n = 1'b1;
    while (!hlt) begin
      @(posedge clk);
      #1;
    end
    assert (pc == exp_halt_pc) else begin
      $display("ERROR pc got %h exp %h", pc, exp_halt_pc);
      errors++;
    end
    repeat (8) @(posedge clk);   // Halted pipe must stay quiet
    #1;
    assert (st_idx == exp_st_addr.size()) else begin
      $display("program %s made %0d of %0d stores", name, st_idx, exp_st_addr.size());
      errors++;
    end
    assert (ld_idx == exp_ld_addr.size()) else begin
      $display("program %s made %0d of %0d loads", name, ld_idx, exp_ld_addr.size());
      errors++;
    end
    bad = (errors != err0) || (u_dut.u_chk.failed != chk0);
    if (bad) begin
      tests_failed++;
    end
    $display("program %s: %0d stores, %0d loads, halted at pc %h, %s",
             name, st_idx, ld_idx, pc, bad ? "failed" : "ok");
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////////////
  initial begin
    clk            = 1'b0;
    arst_n         = 1'b0;
    mem_data_valid = 1'b0;
    mem_data_in    = '0;
    busy           = 1'b0;
    wait_cnt       = 0;
    rd_word        = '0;
    errors         = 0;
    tests_failed   = 0;
    void'($urandom(SEED));
    build_prog_a();
    run_program("A");
    build_prog_b();
    run_program("B");
    chk_fail = u_dut.u_chk.failed;
    $display("tests %0d, failed %0d, check errors %0d, checker flag %0b",
             N_PROGS, tests_failed, errors, chk_fail);
    if (tests_failed == 0 && errors == 0 && !chk_fail) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  // Budget per instruction covers two slow memory round trips
  initial begin
    #(CLK_PERIOD * N_PROGS * (MAX_INSTR * CYC_PER_INSTR + RST_CYCLES + 10));
    $display("watchdog expired, a program did not halt in time");
    $display("=== FAIL ===");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
+incdir+.
proc_pkg.sv
pipe_stage_reg.sv
fetch_unit.sv
mem_port_arbiter.sv
decode_regfile.sv
execute_fwd.sv
hazard_unit.sv
proc_core.sv
proc_chk.sv
tb_proc.sv

// File: run.sh
#!/bin/sh
# Build and run the processor testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module tb_proc -o sim_tb_proc

# Let the run continue past checker errors so the summary is printed
out=$(./obj_dir/sim_tb_proc +verilator+error+limit+1000 2>&1)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx '=== PASS ==='
